/* Bender.yml */
package:
  name: cpu_core

sources:
  - files:
      - rtl/cpuPkg.sv
      - rtl/cpuController.sv
      - rtl/regfileWriteControl.sv
      - rtl/registerFile.sv
      - rtl/alu.sv
      - rtl/programCounter.sv
      - rtl/memPort.sv
      - rtl/cpuCore.sv
  - target: test
    files:
      - verif/memoryModel.sv
      - verif/cpuCoreTb.sv

/* all.f */
rtl/cpuPkg.sv
rtl/cpuController.sv
rtl/regfileWriteControl.sv
rtl/registerFile.sv
rtl/alu.sv
rtl/programCounter.sv
rtl/memPort.sv
rtl/cpuCore.sv
verif/memoryModel.sv
verif/cpuCoreTb.sv

/* rtl/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  logic         clk,
    input  logic         reset,
    input  cpuPkg::aluOp op,
    input  logic [31:0]  a,
    input  logic [31:0]  b,
    input  logic         useImm,
    input  logic [15:0]  imm,
    output logic [31:0]  result,
    output logic         zero
);

    logic [31:0] operandB;
    logic [4:0]  shamt;
    logic [31:0] resultNext;

    assign operandB = useImm ? {{16{imm[15]}}, imm} : b;
    assign shamt    = operandB[4:0];

    always_comb begin
        case (op)
            cpuPkg::ALU_ADD: resultNext = a + operandB;
            cpuPkg::ALU_SUB: resultNext = a - operandB;
            cpuPkg::ALU_AND: resultNext = a & operandB;
            cpuPkg::ALU_OR:  resultNext = a | operandB;
            cpuPkg::ALU_XOR: resultNext = a ^ operandB;
            cpuPkg::ALU_SHL: resultNext = a << shamt;
            cpuPkg::ALU_SHR: resultNext = a >> shamt;
            cpuPkg::ALU_SAR: resultNext = $signed(a) >>> shamt;
            default:         resultNext = a + operandB;
        endcase
    end

    // operands stay put until the next fetch, so the value after EXECUTE holds
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            result <= 32'd0;
        else
            result <= resultNext;
    end

    // branch test on rs
    assign zero = (a == 32'd0);

endmodule

`default_nettype wire

/* rtl/cpuController.sv */
`timescale 1ns/10ps
`default_nettype none

module cpuController (
    input  logic               clk,
    input  logic               reset,
    input  logic               irq,
    input  logic               memDone,
    input  logic               zero,
    input  logic [31:0]        fetchedWord,
    output cpuPkg::instruction instr,
    output cpuPkg::states      state,
    output cpuPkg::memCmd      memCmdOut,
    output cpuPkg::aluOp       aluOpOut,
    output cpuPkg::pcSel       pcSelOut,
    output logic               step
);

    cpuPkg::states nextState;
    logic          intActive;
    logic          isMemOp;
    logic          complete;

    assign isMemOp = instr.opcode inside {cpuPkg::LDD, cpuPkg::LDBS, cpuPkg::LDBU,
                                          cpuPkg::LDWS, cpuPkg::LDWU, cpuPkg::STD};

    // only the two wait states can stall
    assign step = !((state == cpuPkg::FETCHWAIT || state == cpuPkg::MEMWAIT) && !memDone);

    assign memCmdOut = '{start: (state == cpuPkg::FETCH || state == cpuPkg::MEMORY),
                         write: (state == cpuPkg::MEMORY && instr.opcode == cpuPkg::STD),
                         fetch: (state == cpuPkg::FETCH)};

    always_comb begin
        case (instr.opcode)
            cpuPkg::SUB_R,
            cpuPkg::SUB_I: aluOpOut = cpuPkg::ALU_SUB;
            cpuPkg::AND_R: aluOpOut = cpuPkg::ALU_AND;
            cpuPkg::OR_R:  aluOpOut = cpuPkg::ALU_OR;
            cpuPkg::XOR_R: aluOpOut = cpuPkg::ALU_XOR;
            cpuPkg::SHL_I: aluOpOut = cpuPkg::ALU_SHL;
            cpuPkg::SHR_I: aluOpOut = cpuPkg::ALU_SHR;
            cpuPkg::SAR_I: aluOpOut = cpuPkg::ALU_SAR;
            // adds also form load and store addresses
            default:       aluOpOut = cpuPkg::ALU_ADD;
        endcase
    end

    always_comb begin
        nextState = state;
        pcSelOut  = cpuPkg::PC_HOLD;
        complete  = 1'b0;
        case (state)
            cpuPkg::FETCH:     nextState = cpuPkg::FETCHWAIT;
            cpuPkg::FETCHWAIT: if (memDone) nextState = cpuPkg::DECODE;
            cpuPkg::DECODE:    nextState = cpuPkg::EXECUTE;
            cpuPkg::EXECUTE: begin
                if (isMemOp) begin
                    nextState = cpuPkg::MEMORY;
                end else begin
                    complete = 1'b1;
                    if (instr.opcode == cpuPkg::BRZ && zero)
                        pcSelOut = cpuPkg::PC_BRANCH;
                    else if (instr.opcode == cpuPkg::RETI)
                        pcSelOut = cpuPkg::PC_EPC;
                    else
                        pcSelOut = cpuPkg::PC_INC;
                end
            end
            cpuPkg::MEMORY:    nextState = cpuPkg::MEMWAIT;
            cpuPkg::MEMWAIT: begin
                if (memDone) begin
                    complete = 1'b1;
                    pcSelOut = cpuPkg::PC_INC;
                end
            end
            cpuPkg::INTERRUPT: begin
                nextState = cpuPkg::FETCH;
                pcSelOut  = cpuPkg::PC_VECTOR;
            end
            default:           nextState = cpuPkg::FETCH;
        endcase
        // irq sampled at the instruction boundary
        if (complete)
            nextState = (irq && !intActive) ? cpuPkg::INTERRUPT : cpuPkg::FETCH;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= cpuPkg::FETCH;
            intActive <= 1'b0;
        end else begin
            state <= nextState;
            if (nextState == cpuPkg::INTERRUPT)
                intActive <= 1'b1;
            else if (state == cpuPkg::EXECUTE && instr.opcode == cpuPkg::RETI)
                intActive <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (state == cpuPkg::FETCHWAIT && memDone)
            instr <= cpuPkg::instruction'(fetchedWord);
    end

    // a response may only end a wait state
    doneInWaitState: assert property (@(posedge clk) disable iff (reset)
        memDone |-> state inside {cpuPkg::FETCHWAIT, cpuPkg::MEMWAIT});

    stateKnown: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(state));

endmodule

`default_nettype wire

/* rtl/cpuCore.sv */
`timescale 1ns/10ps
`default_nettype none

module cpuCore #(
    parameter logic [31:0] RESET_VECTOR = 32'h0000_0000,
    parameter logic [31:0] IRQ_VECTOR   = 32'h0000_0100,
    parameter int          MEM_CREDITS  = 2
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          irq,
    output cpuPkg::memReq memReqOut,
    input  cpuPkg::memRsp memRspIn,
    input  logic          creditReturn
);

    cpuPkg::instruction instr;
    cpuPkg::states      state;
    cpuPkg::memCmd      memCmdSig;
    cpuPkg::aluOp       aluOpSig;
    cpuPkg::pcSel       pcSelSig;
    cpuPkg::regWriteSel writeSel;
    logic               step;
    logic               memDone;
    logic               zero;
    logic [3:0]         writeAddr;
    logic [31:0]        fetchedWord;
    logic [31:0]        loadData;
    logic [31:0]        result;
    logic [31:0]        rsData;
    logic [31:0]        rdData;
    logic [31:0]        pc;
    logic [31:0]        linkAddr;

    cpuController controller (
        .clk(clk), .reset(reset), .irq(irq), .memDone(memDone), .zero(zero),
        .fetchedWord(fetchedWord), .instr(instr), .state(state), .memCmdOut(memCmdSig),
        .aluOpOut(aluOpSig), .pcSelOut(pcSelSig), .step(step)
    );

    regfileWriteControl writeControl (
        .clk(clk), .reset(reset), .enable(step), .instr(instr), .state(state),
        .conditionResult(zero), .writeSel(writeSel), .writeAddr(writeAddr)
    );

    registerFile regs (
        .clk(clk), .reset(reset), .rs(instr.rs), .rd(instr.rd), .writeSel(writeSel),
        .writeAddr(writeAddr), .result(result), .linkAddr(linkAddr), .loadData(loadData),
        .rsData(rsData), .rdData(rdData)
    );

    // immediate forms are flagged in the opcode itself
    alu aluUnit (
        .clk(clk), .reset(reset), .op(aluOpSig), .a(rsData), .b(rdData),
        .useImm(instr.opcode[cpuPkg::IMM_BIT]), .imm(instr.imm),
        .result(result), .zero(zero)
    );

    programCounter #(.RESET_VECTOR(RESET_VECTOR), .IRQ_VECTOR(IRQ_VECTOR)) pcUnit (
        .clk(clk), .reset(reset), .sel(pcSelSig), .offset(instr.imm),
        .pc(pc), .linkAddr(linkAddr)
    );

    memPort #(.MEM_CREDITS(MEM_CREDITS)) port (
        .clk(clk), .reset(reset), .cmd(memCmdSig), .pc(pc), .addr(result),
        .storeData(rdData), .memReqOut(memReqOut), .memRspIn(memRspIn),
        .creditReturn(creditReturn), .memDone(memDone), .fetchedWord(fetchedWord),
        .loadData(loadData)
    );

endmodule

`default_nettype wire

/* rtl/cpuPkg.sv */
`default_nettype none

package cpuPkg;

    // bit 6 of the opcode marks instructions that take the immediate as operand b
    localparam int IMM_BIT = 6;

    typedef enum logic [7:0] {
        ADD_R = 8'h00,
        SUB_R = 8'h01,
        AND_R = 8'h02,
        OR_R  = 8'h03,
        XOR_R = 8'h04,
        BRZ   = 8'h10,
        RETI  = 8'h11,
        NOP   = 8'h12,
        ADD_I = 8'h40,
        SUB_I = 8'h41,
        SHL_I = 8'h45,
        SHR_I = 8'h46,
        SAR_I = 8'h47,
        LDD   = 8'h48,
        LDBS  = 8'h49,
        LDBU  = 8'h4a,
        LDWS  = 8'h4b,
        LDWU  = 8'h4c,
        STD   = 8'h4d
    } opcodes;

    typedef enum logic [2:0] {
        FETCH,
        FETCHWAIT,
        DECODE,
        EXECUTE,
        MEMORY,
        MEMWAIT,
        INTERRUPT
    } states;

    typedef struct packed {
        opcodes             opcode;
        logic [3:0]         rd;
        logic [3:0]         rs;
        logic signed [15:0] imm;
    } instruction;

    typedef enum logic [2:0] {
        NO_WRITE,
        RESULT_WR,
        LINK_WR,
        DWORD_WR,
        SBYTE_WR,
        SWORD_WR,
        UBYTE_WR,
        UWORD_WR
    } regWriteSel;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SHL,
        ALU_SHR,
        ALU_SAR
    } aluOp;

    typedef enum logic [2:0] {
        PC_HOLD,
        PC_INC,
        PC_BRANCH,
        PC_VECTOR,
        PC_EPC
    } pcSel;

    typedef struct packed {
        logic        valid;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
    } memReq;

    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;
    } memRsp;

    typedef struct packed {
        logic start;
        logic write;
        logic fetch;
    } memCmd;

    localparam logic [3:0] LINK_REG = 4'd14;

endpackage

`default_nettype wire

/* rtl/memPort.sv */
`timescale 1ns/10ps
`default_nettype none

module memPort #(
    parameter int MEM_CREDITS = 2
) (
    input  logic          clk,
    input  logic          reset,
    input  cpuPkg::memCmd cmd,
    input  logic [31:0]   pc,
    input  logic [31:0]   addr,
    input  logic [31:0]   storeData,
    output cpuPkg::memReq memReqOut,
    input  cpuPkg::memRsp memRspIn,
    input  logic          creditReturn,
    output logic          memDone,
    output logic [31:0]   fetchedWord,
    output logic [31:0]   loadData
);

    localparam int CW = $clog2(MEM_CREDITS + 1);

    logic [CW-1:0] creditCount;
    logic          pending;
    cpuPkg::memCmd heldCmd;
    cpuPkg::memCmd activeCmd;
    logic          issue;
    logic          reqValid;
    logic          reqWrite;
    logic [31:0]   reqAddr;
    logic [31:0]   reqData;
    logic          expectFetch;
    logic          expectWrite;

    assign activeCmd = pending ? heldCmd : cmd;
    // back-pressure while no credit is held
    assign issue     = (pending || cmd.start) && creditCount != '0 && !reqValid;
    assign memReqOut = '{valid: reqValid, write: reqWrite, addr: reqAddr, wdata: reqData};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            creditCount <= CW'(MEM_CREDITS);
            pending     <= 1'b0;
            reqValid    <= 1'b0;
            memDone     <= 1'b0;
        end else begin
            creditCount <= creditCount + CW'(creditReturn) - CW'(reqValid);
            reqValid    <= issue;
            memDone     <= memRspIn.valid;
            if (issue)
                pending <= 1'b0;
            else if (cmd.start)
                pending <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.start)
            heldCmd <= cmd;
        if (issue) begin
            reqWrite    <= activeCmd.write;
            reqAddr     <= activeCmd.fetch ? pc : addr;
            reqData     <= storeData;
            expectFetch <= activeCmd.fetch;
            expectWrite <= activeCmd.write;
        end
        // store responses carry no data
        if (memRspIn.valid) begin
            if (expectFetch)
                fetchedWord <= memRspIn.rdata;
            else if (!expectWrite)
                loadData <= memRspIn.rdata;
        end
    end

    noIssueWithoutCredit: assert property (@(posedge clk) disable iff (reset)
        reqValid |-> creditCount != '0);

    creditBound: assert property (@(posedge clk) disable iff (reset)
        creditCount <= MEM_CREDITS);

endmodule

`default_nettype wire

/* rtl/programCounter.sv */
`timescale 1ns/10ps
`default_nettype none

module programCounter #(
    parameter logic [31:0] RESET_VECTOR = 32'h0000_0000,
    parameter logic [31:0] IRQ_VECTOR   = 32'h0000_0100
) (
    input  logic         clk,
    input  logic         reset,
    input  cpuPkg::pcSel sel,
    input  logic [15:0]  offset,
    output logic [31:0]  pc,
    output logic [31:0]  linkAddr
);

    logic [31:0] epc;
    logic [31:0] pcInc;
    logic [31:0] branchTarget;

    assign pcInc        = pc + 32'd4;
    assign branchTarget = pcInc + {{14{offset[15]}}, offset, 2'b00};
    assign linkAddr     = pcInc;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= RESET_VECTOR;
        end else begin
            case (sel)
                cpuPkg::PC_INC:    pc <= pcInc;
                cpuPkg::PC_BRANCH: pc <= branchTarget;
                cpuPkg::PC_VECTOR: pc <= IRQ_VECTOR;
                cpuPkg::PC_EPC:    pc <= epc;
                default:           pc <= pc;
            endcase
        end
    end

    // pc has already advanced past the last instruction when the vector is taken
    always_ff @(posedge clk) begin
        if (sel == cpuPkg::PC_VECTOR)
            epc <= pc;
    end

endmodule

`default_nettype wire

/* rtl/regfileWriteControl.sv */
`timescale 1ns/10ps
`default_nettype none

module regfileWriteControl (
    input  logic               clk,
    input  logic               reset,
    input  logic               enable,
    input  cpuPkg::instruction instr,
    input  cpuPkg::states      state,
    input  logic               conditionResult,
    output cpuPkg::regWriteSel writeSel,
    output logic [3:0]         writeAddr
);

    cpuPkg::regWriteSel selNext;
    logic [3:0]         addrNext;

    always_comb begin
        selNext  = cpuPkg::NO_WRITE;
        addrNext = instr.rd;
        case (state)
            cpuPkg::DECODE: begin
                // link only when the branch is taken
                if (instr.opcode == cpuPkg::BRZ && conditionResult) begin
                    selNext  = cpuPkg::LINK_WR;
                    addrNext = cpuPkg::LINK_REG;
                end
            end
            cpuPkg::EXECUTE: begin
                case (instr.opcode)
                    cpuPkg::ADD_R, cpuPkg::ADD_I,
                    cpuPkg::SUB_R, cpuPkg::SUB_I,
                    cpuPkg::AND_R, cpuPkg::OR_R, cpuPkg::XOR_R,
                    cpuPkg::SHL_I, cpuPkg::SHR_I, cpuPkg::SAR_I: selNext = cpuPkg::RESULT_WR;
                    default:                                    selNext = cpuPkg::NO_WRITE;
                endcase
            end
            cpuPkg::MEMWAIT: begin
                case (instr.opcode)
                    cpuPkg::LDD:  selNext = cpuPkg::DWORD_WR;
                    cpuPkg::LDBS: selNext = cpuPkg::SBYTE_WR;
                    cpuPkg::LDBU: selNext = cpuPkg::UBYTE_WR;
                    cpuPkg::LDWS: selNext = cpuPkg::SWORD_WR;
                    cpuPkg::LDWU: selNext = cpuPkg::UWORD_WR;
                    default:      selNext = cpuPkg::NO_WRITE;
                endcase
            end
            default: selNext = cpuPkg::NO_WRITE;
        endcase
    end

    // holds while stalled
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            writeSel  <= cpuPkg::NO_WRITE;
            writeAddr <= 4'd0;
        end else if (enable) begin
            writeSel  <= selNext;
            writeAddr <= addrNext;
        end
    end

endmodule

`default_nettype wire

/* rtl/registerFile.sv */
`timescale 1ns/10ps
`default_nettype none

module registerFile (
    input  logic               clk,
    input  logic               reset,
    input  logic [3:0]         rs,
    input  logic [3:0]         rd,
    input  cpuPkg::regWriteSel writeSel,
    input  logic [3:0]         writeAddr,
    input  logic [31:0]        result,
    input  logic [31:0]        linkAddr,
    input  logic [31:0]        loadData,
    output logic [31:0]        rsData,
    output logic [31:0]        rdData
);

    logic [31:0] regs [16];
    logic [31:0] writeData;

    // load extension from the low bits of the response word
    always_comb begin
        case (writeSel)
            cpuPkg::RESULT_WR: writeData = result;
            cpuPkg::LINK_WR:   writeData = linkAddr;
            cpuPkg::DWORD_WR:  writeData = loadData;
            cpuPkg::SBYTE_WR:  writeData = {{24{loadData[7]}}, loadData[7:0]};
            cpuPkg::UBYTE_WR:  writeData = {24'd0, loadData[7:0]};
            cpuPkg::SWORD_WR:  writeData = {{16{loadData[15]}}, loadData[15:0]};
            cpuPkg::UWORD_WR:  writeData = {16'd0, loadData[15:0]};
            default:           writeData = result;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (writeSel != cpuPkg::NO_WRITE) begin
            regs[writeAddr] <= writeData;
        end
    end

    assign rsData = regs[rs];
    assign rdData = regs[rd];

endmodule

`default_nettype wire

/* verif/cpuCoreTb.sv */
`timescale 1ns/10ps
`default_nettype none

module cpuCoreTb;

    localparam int          MEM_CREDITS = 2;
    localparam logic [31:0] IRQ_VEC     = 32'h0000_0100;
    localparam logic [31:0] DATA_ADDR   = 32'h0000_0200;
    localparam logic [31:0] FLAG_ADDR   = 32'h0000_03f0;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } memWord;

    logic          clk;
    logic          reset;
    logic          irq;
    cpuPkg::memReq memReq;
    cpuPkg::memRsp memRsp;
    logic          creditReturn;

    memWord image [$];
    memWord expected [$];
    memWord stores [$];
    logic [31:0] pcAddr;
    int          irqAfter;
    int          outstanding;
    int          reqCount;
    int          rspCount;
    logic        sawVector;

    cpuCore #(
        .RESET_VECTOR(32'h0), .IRQ_VECTOR(IRQ_VEC), .MEM_CREDITS(MEM_CREDITS)
    ) uut (
        .clk(clk), .reset(reset), .irq(irq), .memReqOut(memReq), .memRspIn(memRsp),
        .creditReturn(creditReturn)
    );

    memoryModel #(.SLOTS(MEM_CREDITS)) memory (
        .clk(clk), .reset(reset), .memReqIn(memReq), .memRspOut(memRsp),
        .creditReturn(creditReturn)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] encode(cpuPkg::opcodes op, int rd, int rs, int imm);
        logic [3:0] rdBits;
        logic [3:0] rsBits;
        logic [15:0] immBits;
        rdBits  = rd[3:0];
        rsBits  = rs[3:0];
        immBits = imm[15:0];
        return {op, rdBits, rsBits, immBits};
    endfunction

    task automatic emit(logic [31:0] word);
        image.push_back('{addr: pcAddr, data: word});
        pcAddr += 4;
    endtask

    task automatic expectStore(logic [31:0] addr, logic [31:0] data);
        expected.push_back('{addr: addr, data: data});
    endtask

    task automatic failRun(string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    // store into the output area, base register r0
    task automatic storeTo(int rd, logic [31:0] addr, logic [31:0] data);
        emit(encode(cpuPkg::STD, rd, 0, addr));
        expectStore(addr, data);
    endtask

    task automatic buildProgram();
        logic [31:0] brAddr;
        pcAddr = 32'h0;
        emit(encode(cpuPkg::ADD_I, 1, 0, 16'h1234));
        emit(encode(cpuPkg::ADD_I, 2, 0, -3));
        emit(encode(cpuPkg::ADD_I, 7, 0, 16'h0ff0));
        emit(encode(cpuPkg::ADD_I, 13, 0, 16'h5a5a));
        // register forms compute rd = rs op rd
        emit(encode(cpuPkg::ADD_I, 3, 1, 0));
        emit(encode(cpuPkg::ADD_R, 3, 2, 0));
        storeTo(3, 32'h300, 32'h0000_1234 + 32'hffff_fffd);
        emit(encode(cpuPkg::ADD_I, 4, 1, 0));
        emit(encode(cpuPkg::SUB_R, 4, 2, 0));
        storeTo(4, 32'h304, 32'hffff_fffd - 32'h0000_1234);
        emit(encode(cpuPkg::SUB_I, 5, 1, 16'h0034));
        storeTo(5, 32'h308, 32'h0000_1234 - 32'h34);
        emit(encode(cpuPkg::ADD_I, 6, 7, 0));
        emit(encode(cpuPkg::AND_R, 6, 1, 0));
        storeTo(6, 32'h30c, 32'h1234 & 32'h0ff0);
        emit(encode(cpuPkg::ADD_I, 6, 7, 0));
        emit(encode(cpuPkg::OR_R, 6, 1, 0));
        storeTo(6, 32'h310, 32'h1234 | 32'h0ff0);
        emit(encode(cpuPkg::ADD_I, 6, 7, 0));
        emit(encode(cpuPkg::XOR_R, 6, 1, 0));
        storeTo(6, 32'h314, 32'h1234 ^ 32'h0ff0);
        emit(encode(cpuPkg::SHL_I, 8, 1, 4));
        storeTo(8, 32'h318, 32'h1234 << 4);
        emit(encode(cpuPkg::SHR_I, 8, 2, 4));
        storeTo(8, 32'h31c, 32'hffff_fffd >> 4);
        emit(encode(cpuPkg::SAR_I, 8, 2, 1));
        storeTo(8, 32'h320, 32'hffff_fffe);
        // loads of 8765c3a9
        emit(encode(cpuPkg::LDD, 9, 0, DATA_ADDR));
        storeTo(9, 32'h324, 32'h8765_c3a9);
        emit(encode(cpuPkg::LDBS, 9, 0, DATA_ADDR));
        storeTo(9, 32'h328, 32'hffff_ffa9);
        emit(encode(cpuPkg::LDBU, 9, 0, DATA_ADDR));
        storeTo(9, 32'h32c, 32'h0000_00a9);
        emit(encode(cpuPkg::LDWS, 9, 0, DATA_ADDR));
        storeTo(9, 32'h330, 32'hffff_c3a9);
        emit(encode(cpuPkg::LDWU, 9, 0, DATA_ADDR));
        storeTo(9, 32'h334, 32'h0000_c3a9);
        // taken branch skips one word, link is the branch address plus 4
        brAddr = pcAddr;
        emit(encode(cpuPkg::BRZ, 0, 0, 1));
        emit(encode(cpuPkg::STD, 1, 0, 16'h03e0));
        storeTo(14, 32'h340, brAddr + 4);
        emit(encode(cpuPkg::BRZ, 0, 1, 1));
        storeTo(14, 32'h344, brAddr + 4);
        irqAfter = expected.size() - 1;
        // spin on the flag until the handler sets it
        emit(encode(cpuPkg::LDD, 10, 0, FLAG_ADDR));
        emit(encode(cpuPkg::BRZ, 0, 10, -2));
        expectStore(FLAG_ADDR, 32'h5a5a);
        storeTo(10, 32'h348, 32'h5a5a);
        emit(encode(cpuPkg::BRZ, 0, 0, -1));
        image.push_back('{addr: IRQ_VEC, data: encode(cpuPkg::STD, 13, 0, FLAG_ADDR)});
        image.push_back('{addr: IRQ_VEC + 4, data: encode(cpuPkg::RETI, 0, 0, 0)});
        image.push_back('{addr: DATA_ADDR, data: 32'h8765_c3a9});
        image.push_back('{addr: FLAG_ADDR, data: 32'h0});
    endtask

    // bus monitors sample away from the active edge
    always @(negedge clk) begin
        if (!reset) begin
            outstanding = outstanding + int'(memReq.valid) - int'(creditReturn);
            assert (outstanding >= 0 && outstanding <= MEM_CREDITS) else
                failRun($sformatf("Fail at time %0t: %0d requests outstanding",
                                  $time, outstanding));
            if (memReq.valid) begin
                reqCount++;
                if (memReq.write) begin
                    stores.push_back('{addr: memReq.addr, data: memReq.wdata});
                end else if (memReq.addr == IRQ_VEC) begin
                    // the vector is only entered on a pending irq
                    assert (irq) else
                        failRun("The core fetched from the irq vector with no irq pending");
                    sawVector = 1'b1;
                end
            end
            if (memRsp.valid)
                rspCount++;
            assert (rspCount <= reqCount) else
                failRun("The memory answered a request that was never issued");
        end
    end

    always @(posedge clk) begin
        if (sawVector)
            irq <= 1'b0;
    end

    initial begin
        int waited;
        memWord got;
        void'($urandom(32'ha298));
        reset       = 1'b1;
        irq         = 1'b0;
        outstanding = 0;
        reqCount    = 0;
        rspCount    = 0;
        sawVector   = 1'b0;
        buildProgram();
        @(posedge clk);
        foreach (image[i]) begin
            memory.mem[image[i].addr >> 2] = image[i].data;
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        foreach (expected[i]) begin
            waited = 0;
            while (stores.size() == 0 && waited < 3000) begin
                @(posedge clk);
                waited++;
            end
            assert (stores.size() != 0) else
                failRun($sformatf("Timeout: store %0d to address %08h never arrived",
                                  i, expected[i].addr));
            got = stores.pop_front();
            assert (got == expected[i]) else
                failRun($sformatf("Fail at time %0t: store %0d got %08h to %08h, expected %08h to %08h",
                                  $time, i, got.data, got.addr, expected[i].data, expected[i].addr));
            if (i == irqAfter)
                irq <= 1'b1;
        end
        waited = 0;
        @(negedge clk);
        while (reqCount != rspCount && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        assert (reqCount == rspCount) else
            failRun("A memory request was never answered");
        assert (stores.size() == 0) else
            failRun($sformatf("Fail at time %0t: unexpected store to %08h",
                              $time, stores[0].addr));
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/memoryModel.sv */
`timescale 1ns/10ps
`default_nettype none

module memoryModel #(
    parameter int SLOTS = 2,
    parameter int DEPTH = 1024
) (
    input  logic          clk,
    input  logic          reset,
    input  cpuPkg::memReq memReqIn,
    output cpuPkg::memRsp memRspOut,
    output logic          creditReturn
);

    logic [31:0] mem [DEPTH];
    logic [31:0] pendAddr [$];
    logic        pendWrite [$];
    int          pendDue [$];
    int          cycle;
    int          freed;

    // every word differs, so a stray fetch or load shows up
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = i * 32'h9e37_79b1;
        end
    end

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            memRspOut    <= '0;
            creditReturn <= 1'b0;
            cycle = 0;
            freed = 0;
            pendAddr.delete();
            pendWrite.delete();
            pendDue.delete();
        end else begin
            cycle++;
            memRspOut.valid <= 1'b0;
            // responses leave in request order
            if (pendDue.size() > 0 && pendDue[0] <= cycle) begin
                memRspOut.valid <= 1'b1;
                memRspOut.rdata <= pendWrite[0] ? 32'd0 : mem[(pendAddr[0] >> 2) % DEPTH];
                void'(pendAddr.pop_front());
                void'(pendWrite.pop_front());
                void'(pendDue.pop_front());
                freed++;
            end
            // with every slot in use the request is lost
            if (memReqIn.valid && pendDue.size() + freed < SLOTS) begin
                if (memReqIn.write)
                    mem[(memReqIn.addr >> 2) % DEPTH] = memReqIn.wdata;
                pendAddr.push_back(memReqIn.addr);
                pendWrite.push_back(memReqIn.write);
                pendDue.push_back(cycle + 1 + ($urandom % 6));
            end
            // freed slots are handed back late at random
            creditReturn <= 1'b0;
            if (freed > 0 && ($urandom % 3) != 0) begin
                creditReturn <= 1'b1;
                freed--;
            end
        end
    end

endmodule

`default_nettype wire
